/* common/lc3b_settings.svh */
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// datapath width of the slice.
`define LC3B_WORD_WIDTH 16

// register file geometry.
`define LC3B_NUM_REGS 8
`define LC3B_REG_WIDTH 3

`endif

/* common/lc3b_types.sv */
`default_nettype none

`include "lc3b_settings.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
    typedef logic [`LC3B_REG_WIDTH-1:0] lc3b_reg;

    // ########################################
    // opcodes and ALU operations
    // ########################################

    // only the operate group is decoded, every other code is a bubble.
    typedef enum logic [3:0]
    {
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0]
    {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // ########################################
    // control word
    // ########################################

    // an all-zero word never writes and so acts as a bubble.
    typedef struct packed
    {
        lc3b_aluop aluop;
        logic use_imm; // second operand is imm5 instead of sr2.
        logic reg_write;
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

/* common/lc3b_pipe_types.sv */
`default_nettype none

package lc3b_pipe_types;

    // ########################################
    // input handshake
    // ########################################

    // four-phase req/ack sequence seen from the receiving side.
    // hs_idle waits for a request and accepts it.
    // hs_ack holds ack until the request is withdrawn.
    // hs_release keeps ack up one more cycle before dropping it.
    typedef enum logic [1:0]
    {
        hs_idle,
        hs_ack,
        hs_release
    } hs_state;

endpackage : lc3b_pipe_types

`default_nettype wire

/* src/pipe_control.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_control
    import lc3b_pipe_types::*;
(
    input wire clk,
    input wire rst,
    input wire instr_req,
    input wire flush,
    output logic instr_ack,
    output logic load,
    output logic advance,
    output logic flush_all
);

    hs_state state;
    logic dec_valid; // decode stage holds an accepted instruction.

    assign flush_all = rst | flush;
    assign load = (state == hs_idle) && instr_req;
    assign advance = dec_valid && !flush_all; // flush wins over advance.
    assign instr_ack = (state != hs_idle);

    // ########################################
    // handshake FSM
    // ########################################

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= hs_idle;
        else
        begin
            case (state)
                hs_idle:
                    if (instr_req)
                        state <= hs_ack;
                hs_ack:
                    if (!instr_req)
                        state <= hs_release;
                hs_release:
                    state <= hs_idle; // ack drops on this edge.
                default:
                    state <= hs_idle;
            endcase
        end
    end

    // an entry sits in decode for exactly one cycle before it moves on.
    always_ff @(posedge clk)
    begin
        if (flush_all)
            dec_valid <= 1'b0;
        else if (load)
            dec_valid <= 1'b1;
        else if (advance)
            dec_valid <= 1'b0;
    end

    // ########################################
    // checks
    // ########################################

    // the outside must withdraw its request before ack may fall.
    a_ack_held: assert property (@(posedge clk) disable iff (rst)
        (instr_ack && instr_req) |=> instr_ack)
        else $error("instr_ack dropped while instr_req was high.");

    // the idle phase comes back only after decode has passed its entry on.
    a_load_idle: assert property (@(posedge clk) disable iff (rst)
        load |-> !dec_valid)
        else $error("load while decode still held an instruction.");

endmodule : pipe_control

`default_nettype wire

/* decode/lc3b_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_settings.svh"

module lc3b_decode
    import lc3b_types::*;
(
    input wire clk,
    input wire load,
    input wire flush_all,
    input wire lc3b_word instr,
    output lc3b_word pc,
    output lc3b_reg dest,
    output lc3b_reg src1,
    output lc3b_reg src2,
    output lc3b_word imm5,
    output lc3b_control_word ctrl_word
);

    lc3b_word instr_q;
    lc3b_word pc_q;
    lc3b_opcode opcode;

    // a cleared latch decodes as opcode 0000, which is a bubble.
    always_ff @(posedge clk)
    begin
        if (flush_all)
        begin
            instr_q <= '0;
            pc_q <= '0;
        end
        else if (load)
        begin
            instr_q <= instr;
            pc_q <= pc_q + lc3b_word'(1);
        end
    end

    assign pc = pc_q;
    assign opcode = lc3b_opcode'(instr_q[15:12]);

    // ########################################
    // fields
    // ########################################

    assign dest = instr_q[11:9];
    assign src1 = instr_q[8:6];
    assign src2 = (opcode == op_not) ? instr_q[8:6] : instr_q[2:0]; // NOT reads sr1 twice.
    assign imm5 = {{(`LC3B_WORD_WIDTH-5){instr_q[4]}}, instr_q[4:0]};

    always_comb
    begin
        ctrl_word = '0;
        case (opcode)
            op_add:
            begin
                ctrl_word.aluop = alu_add;
                ctrl_word.use_imm = instr_q[5];
                ctrl_word.reg_write = 1'b1;
            end
            op_and:
            begin
                ctrl_word.aluop = alu_and;
                ctrl_word.use_imm = instr_q[5];
                ctrl_word.reg_write = 1'b1;
            end
            op_not:
            begin
                ctrl_word.aluop = alu_not;
                ctrl_word.reg_write = 1'b1;
            end
            default:
                ctrl_word = '0; // unsupported codes pass through as bubbles.
        endcase
    end

endmodule : lc3b_decode

`default_nettype wire

/* decode/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_settings.svh"

module regfile
    import lc3b_types::*;
(
    input wire clk,
    input wire rst,
    input wire write,
    input wire lc3b_reg waddr,
    input wire lc3b_word wdata,
    input wire lc3b_reg raddr1,
    input wire lc3b_reg raddr2,
    output lc3b_word rdata1,
    output lc3b_word rdata2
);

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (write)
            regs[waddr] <= wdata;
    end

    // a write in the same cycle is forwarded so the reader needs no stall.
    assign rdata1 = (write && (waddr == raddr1)) ? wdata : regs[raddr1];
    assign rdata2 = (write && (waddr == raddr2)) ? wdata : regs[raddr2];

endmodule : regfile

`default_nettype wire

/* src/idex.sv */
`timescale 1ns/1ns
`default_nettype none

module idex
    import lc3b_types::*;
(
    input wire clk,
    input wire advance,
    input wire flush,
    input wire lc3b_word pc_in,
    input wire lc3b_control_word ctrl_word_in,
    input wire lc3b_reg dest_in,
    input wire lc3b_word sr1_in,
    input wire lc3b_word sr2_in,
    input wire lc3b_word imm5_in,
    output lc3b_word pc,
    output lc3b_control_word ctrl_word_out,
    output lc3b_reg dest_out,
    output lc3b_word sr1_out,
    output lc3b_word sr2_out,
    output lc3b_word imm5_out
);

    // flush loads a bubble, advance captures, otherwise the entry holds.
    always_ff @(posedge clk)
    begin
        if (flush)
        begin
            pc <= '0;
            ctrl_word_out <= '0;
            dest_out <= '0;
            sr1_out <= '0;
            sr2_out <= '0;
            imm5_out <= '0;
        end
        else if (advance)
        begin
            pc <= pc_in;
            ctrl_word_out <= ctrl_word_in;
            dest_out <= dest_in;
            sr1_out <= sr1_in;
            sr2_out <= sr2_in;
            imm5_out <= imm5_in;
        end
    end

    // the controller masks advance with flush, so both never arrive together.
    a_no_adv_flush: assert property (@(posedge clk) !(advance && flush))
        else $error("advance and flush asserted in the same cycle.");

endmodule : idex

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import lc3b_types::*;
(
    input wire lc3b_control_word ctrl_word,
    input wire lc3b_reg dest,
    input wire lc3b_word sr1,
    input wire lc3b_word sr2,
    input wire lc3b_word imm5,
    output logic wb_valid,
    output lc3b_reg wb_reg,
    output lc3b_word wb_data
);

    lc3b_word operand_b;
    lc3b_word alu_out;

    assign operand_b = ctrl_word.use_imm ? imm5 : sr2;

    // ########################################
    // ALU
    // ########################################

    always_comb
    begin
        case (ctrl_word.aluop)
            alu_add:
                alu_out = sr1 + operand_b;
            alu_and:
                alu_out = sr1 & operand_b;
            alu_not:
                alu_out = ~sr1;
            alu_pass:
                alu_out = sr1;
            default:
                alu_out = sr1;
        endcase
    end

    // the register file takes this write at the end of the cycle.
    assign wb_valid = ctrl_word.reg_write;
    assign wb_reg = dest;
    assign wb_data = alu_out;

endmodule : execute_stage

`default_nettype wire

/* src/lc3b_slice.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_slice
    import lc3b_types::*;
(
    input wire clk,
    input wire rst,
    input wire instr_req,
    input wire lc3b_word instr,
    input wire flush,
    output logic instr_ack,
    output logic wb_valid,
    output lc3b_reg wb_reg,
    output lc3b_word wb_data
);

    logic load;
    logic advance;
    logic flush_all;

    lc3b_word dec_pc;
    lc3b_reg dec_dest;
    lc3b_reg dec_src1;
    lc3b_reg dec_src2;
    lc3b_word dec_imm5;
    lc3b_control_word dec_ctrl;
    lc3b_word rf_rdata1;
    lc3b_word rf_rdata2;

    lc3b_control_word ex_ctrl;
    lc3b_reg ex_dest;
    lc3b_word ex_sr1;
    lc3b_word ex_sr2;
    lc3b_word ex_imm5;

    pipe_control pipe_control_inst (
        .clk(clk), .rst(rst), .instr_req(instr_req), .flush(flush),
        .instr_ack(instr_ack), .load(load), .advance(advance), .flush_all(flush_all)
    );

    lc3b_decode lc3b_decode_inst (
        .clk(clk), .load(load), .flush_all(flush_all), .instr(instr),
        .pc(dec_pc), .dest(dec_dest), .src1(dec_src1), .src2(dec_src2),
        .imm5(dec_imm5), .ctrl_word(dec_ctrl)
    );

    regfile regfile_inst (
        .clk(clk), .rst(rst), .write(wb_valid), .waddr(wb_reg), .wdata(wb_data),
        .raddr1(dec_src1), .raddr2(dec_src2), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    // the pc travels with the entry but nothing in execute consumes it.
    idex idex_inst (
        .clk(clk), .advance(advance), .flush(flush_all),
        .pc_in(dec_pc), .ctrl_word_in(dec_ctrl), .dest_in(dec_dest),
        .sr1_in(rf_rdata1), .sr2_in(rf_rdata2), .imm5_in(dec_imm5),
        .pc(), .ctrl_word_out(ex_ctrl), .dest_out(ex_dest),
        .sr1_out(ex_sr1), .sr2_out(ex_sr2), .imm5_out(ex_imm5)
    );

    execute_stage execute_stage_inst (
        .ctrl_word(ex_ctrl), .dest(ex_dest), .sr1(ex_sr1), .sr2(ex_sr2), .imm5(ex_imm5),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
    );

endmodule : lc3b_slice

`default_nettype wire

/* testbench/tb_lc3b_slice.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_slice;

    localparam int NUM_ROWS = 13;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 12 + 50;

    typedef struct packed
    {
        logic [15:0] instr;
        logic flush; // flush while the entry sits in decode.
        logic write; // a register write is expected.
    } row_t;

    logic clk;
    logic rst;
    logic instr_req;
    logic [15:0] instr;
    logic flush;
    wire instr_ack;
    wire wb_valid;
    wire [2:0] wb_reg;
    wire [15:0] wb_data;

    logic [15:0] model_regs [8];
    logic prev_valid; // execute holds its entry until the next advance.
    int value_errors;
    int protocol_errors;

    // ########################################
    // stimulus table
    // ########################################

    row_t rows [NUM_ROWS] = '{
        '{16'h1227, 1'b0, 1'b1}, // ADD R1, R0, #7.
        '{16'h143D, 1'b0, 1'b1}, // ADD R2, R0, #-3.
        '{16'h1642, 1'b0, 1'b1}, // ADD R3, R1, R2.
        '{16'h58BE, 1'b0, 1'b1}, // AND R4, R2, #-2.
        '{16'h5AC4, 1'b0, 1'b1}, // AND R5, R3, R4.
        '{16'h9CBF, 1'b0, 1'b1}, // NOT R6, R2.
        '{16'h1DAF, 1'b0, 1'b1}, // ADD R6, R6, #15 right behind its producer.
        '{16'h5FB0, 1'b0, 1'b1}, // AND R7, R6, #-16.
        '{16'h1241, 1'b1, 1'b0}, // ADD R1, R1, R1 flushed in flight.
        '{16'h2A85, 1'b0, 1'b0}, // LDB is not decoded here.
        '{16'h1241, 1'b0, 1'b1}, // ADD R1, R1, R1 after a bubble.
        '{16'h91FF, 1'b0, 1'b1}, // NOT R0, R7.
        '{16'h1403, 1'b0, 1'b1}  // ADD R2, R0, R3.
    };

    lc3b_slice lc3b_slice_inst (
        .clk(clk), .rst(rst), .instr_req(instr_req), .instr(instr), .flush(flush),
        .instr_ack(instr_ack), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    function automatic logic [15:0] sign_extend5(input logic [4:0] value);
        return {{11{value[4]}}, value};
    endfunction

    // result of an operate instruction on the current model contents.
    function automatic logic [15:0] model_result(input logic [15:0] ins);
        logic [15:0] a;
        logic [15:0] b;
        a = model_regs[ins[8:6]];
        b = ins[5] ? sign_extend5(ins[4:0]) : model_regs[ins[2:0]];
        case (ins[15:12])
            4'b0001: return a + b;
            4'b0101: return a & b;
            4'b1001: return ~a;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp, input int row);
        assert (got === exp)
        else
        begin
            value_errors++;
            $display("error: %s = 0x%h, expected 0x%h (row %0d)", name, got, exp, row);
        end
    endtask

    task automatic check_protocol(input logic ok, input string what, input int row);
        assert (ok)
        else
        begin
            protocol_errors++;
            $display("row %0d: %s", row, what);
        end
    endtask

    // counts falling edges until instr_ack reaches the level, giving up after ten.
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (instr_ack !== level && cycles < 10);
    endtask

    // ########################################
    // one four-phase transfer per row
    // ########################################

    task automatic apply_row(input int r);
        row_t row;
        logic [15:0] exp_data;
        int cycles;
        row = rows[r];
        instr = row.instr;
        instr_req = 1'b1;
        wait_ack(1'b1, cycles);
        check_protocol(cycles == 1,
                       "instr_ack did not rise on the first edge after the request", r);
        check_value("wb_valid", 16'(wb_valid), 16'(prev_valid), r); // too early for this entry.
        exp_data = model_result(row.instr);
        instr_req = 1'b0;
        flush = row.flush;
        @(negedge clk);
        flush = 1'b0;
        check_value("wb_valid", 16'(wb_valid), 16'(row.write), r);
        if (row.write)
        begin
            check_value("wb_reg", 16'(wb_reg), 16'(row.instr[11:9]), r);
            check_value("wb_data", wb_data, exp_data, r);
            model_regs[row.instr[11:9]] = exp_data; // written on the coming edge.
        end
        prev_valid = row.write;
        check_protocol(instr_ack === 1'b1,
                       "instr_ack fell on the edge that first saw instr_req low", r);
        wait_ack(1'b0, cycles);
        check_protocol(cycles == 1, "instr_ack did not fall one edge after the release phase", r);
    endtask

    initial
    begin
        rst = 1'b1;
        instr_req = 1'b0;
        instr = 16'h0000;
        flush = 1'b0;
        prev_valid = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        for (int i = 0; i < 8; i++)
            model_regs[i] = 16'h0000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (instr_ack === 1'b0 && wb_valid === 1'b0)
        else
        begin
            protocol_errors++;
            $display("instr_ack or wb_valid is high right after reset");
        end
        for (int r = 0; r < NUM_ROWS; r++)
            apply_row(r);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the handshake stopped moving",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_lc3b_slice

`default_nettype wire

/* verilog.f */
+incdir+common
common/lc3b_types.sv
common/lc3b_pipe_types.sv
src/pipe_control.sv
decode/lc3b_decode.sv
decode/regfile.sv
src/idex.sv
src/execute_stage.sv
src/lc3b_slice.sv
testbench/tb_lc3b_slice.sv

/* Makefile */
SHELL := /bin/bash

VERILATOR ?= verilator
TOP ?= tb_lc3b_slice
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	set -o pipefail; ./$(BIN) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
